// File: src/llc_pkg.sv
package llc_pkg;

  // axi address width in bits
  localparam int unsigned AddrWidth   = 32;
  // data bus is 8 bytes wide
  localparam int unsigned ByteOffset  = 3;
  // four blocks per cache line
  localparam int unsigned BlockOffset = 2;
  // address bit where the line index starts, a line is 32 bytes
  localparam int unsigned LineOffset  = ByteOffset + BlockOffset;
  // number of cache ways
  localparam int unsigned SetAssoc    = 4;
  // lines held by one way
  localparam int unsigned NumLines    = 64;
  // scratchpad bytes mapped onto one way
  localparam int unsigned WaySpmBytes = (1 << LineOffset) * NumLines;

  typedef logic [AddrWidth-1:0] addr_t;
  // beats minus one, as on the axi bus
  typedef logic [7:0]           len_t;
  // log2 of the bytes per beat
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           burst_t;
  typedef logic [3:0]           id_t;
  // one bit per way
  typedef logic [SetAssoc-1:0]  way_ind_t;
  typedef logic [1:0]           resp_t;

  localparam resp_t  RespOkay   = 2'b00;
  localparam resp_t  RespSlvErr = 2'b10;

  // wrap bursts are handled as incr
  localparam burst_t BurstFixed = 2'b00;
  localparam burst_t BurstIncr  = 2'b01;

  // one aw or ar request
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } chan_t;

  // the part of a burst that falls onto a single cache line
  typedef struct packed {
    id_t      id;
    addr_t    addr;
    len_t     len;
    size_t    size;
    burst_t   burst;
    // high for writes
    logic     rw;
    logic     spm;
    way_ind_t way_ind;
    resp_t    resp;
    // marks the final line of the burst
    logic     last;
  } desc_t;

  // half-open address region, end_addr itself is outside
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  typedef enum logic [2:0] {
    IDLE,
    CAPTURE_ACK,
    WAIT_REQ_LOW,
    DESC_REQ,
    DESC_ACK_LOW
  } split_state_t;

endpackage

// File: src/llc_addr_decode.sv
module llc_addr_decode (
  input  llc_pkg::addr_t    addr_i,
  input  llc_pkg::rule_t    cached_rule_i,
  // only start_addr of this rule is looked at
  input  llc_pkg::rule_t    spm_rule_i,
  output logic              spm_o,
  output llc_pkg::way_ind_t way_ind_o,
  output logic              dec_err_o
);

  logic in_cached;

  // cached region check against the half-open interval
  assign in_cached = (addr_i >= cached_rule_i.start_addr) &&
                     (addr_i <  cached_rule_i.end_addr);

  always_comb begin
    llc_pkg::addr_t region_start;
    llc_pkg::addr_t region_end;

    // nothing matched yet
    spm_o     = 1'b0;
    way_ind_o = '0;
    dec_err_o = 1'b1;

    // scratchpad regions sit back to back, way 0 first
    region_start = spm_rule_i.start_addr;
    region_end   = spm_rule_i.start_addr;
    for (int unsigned k = 0; k < llc_pkg::SetAssoc; k++) begin
      region_end = region_start + llc_pkg::addr_t'(llc_pkg::WaySpmBytes);
      if ((addr_i >= region_start) && (addr_i < region_end)) begin
        spm_o        = 1'b1;
        way_ind_o[k] = 1'b1;
        dec_err_o    = 1'b0;
      end
      // next way starts where this one ends
      region_start = region_end;
    end

    // the cached region wins on overlap
    if (in_cached) begin
      spm_o     = 1'b0;
      way_ind_o = '0;
      dec_err_o = 1'b0;
    end
  end

endmodule

// File: src/llc_burst_cutter.sv
module llc_burst_cutter (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // whole remaining transfer of this request
  input  llc_pkg::chan_t curr_chan_i,
  // 1 for aw, 0 for ar
  input  logic           rw_i,
  input  llc_pkg::rule_t cached_rule_i,
  input  llc_pkg::rule_t spm_rule_i,
  // transfer left over once the current line is done
  output llc_pkg::chan_t next_chan_o,
  output llc_pkg::desc_t desc_o
);

  // line address of the current beat, tag included
  llc_pkg::addr_t    this_line_addr;
  llc_pkg::addr_t    next_line_addr;
  // bytes from the current address up to the line end
  llc_pkg::addr_t    bytes_on_line;
  llc_pkg::len_t     beats_on_line;

  logic              dec_spm;
  llc_pkg::way_ind_t dec_way_ind;
  logic              dec_err;

  llc_addr_decode i_addr_decode (
    .addr_i        (curr_chan_i.addr),
    .cached_rule_i (cached_rule_i),
    .spm_rule_i    (spm_rule_i),
    .spm_o         (dec_spm),
    .way_ind_o     (dec_way_ind),
    .dec_err_o     (dec_err)
  );

  // clear the offset bits to get the line base
  assign this_line_addr = {curr_chan_i.addr[llc_pkg::AddrWidth-1:llc_pkg::LineOffset],
                           {llc_pkg::LineOffset{1'b0}}};
  assign next_line_addr = this_line_addr + (llc_pkg::addr_t'(1) << llc_pkg::LineOffset);
  assign bytes_on_line  = next_line_addr - curr_chan_i.addr;
  // round up, an unaligned first beat still counts as one
  assign beats_on_line  = llc_pkg::len_t'((bytes_on_line - llc_pkg::addr_t'(1)) >>
                                          curr_chan_i.size) + llc_pkg::len_t'(1);

  always_comb begin
    next_chan_o     = curr_chan_i;

    desc_o.id       = curr_chan_i.id;
    desc_o.addr     = curr_chan_i.addr;
    desc_o.len      = curr_chan_i.len;
    desc_o.size     = curr_chan_i.size;
    desc_o.burst    = curr_chan_i.burst;
    desc_o.rw       = rw_i;
    desc_o.spm      = dec_spm;
    desc_o.way_ind  = dec_way_ind;
    desc_o.resp     = llc_pkg::RespOkay;
    desc_o.last     = 1'b1;

    // unmapped address, steer to way 0 and flag an error
    if (dec_err) begin
      desc_o.spm     = 1'b1;
      desc_o.way_ind = llc_pkg::way_ind_t'(1);
      desc_o.resp    = llc_pkg::RespSlvErr;
    end

    // beats spill over onto the next line
    if (((beats_on_line - llc_pkg::len_t'(1)) < curr_chan_i.len) &&
        (curr_chan_i.burst != llc_pkg::BurstFixed)) begin
      desc_o.len       = beats_on_line - llc_pkg::len_t'(1);
      desc_o.last      = 1'b0;
      next_chan_o.addr = next_line_addr;
      next_chan_o.len  = curr_chan_i.len - beats_on_line;
    end
  end

  // catches a wrap of the address space at the top line
  line_rollover: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    next_line_addr > this_line_addr)
    else $error("burst cutter: next line %h not above line %h", next_line_addr, this_line_addr);

  next_line_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    next_line_addr >= curr_chan_i.addr)
    else $error("burst cutter: next line %h below address %h", next_line_addr,
                curr_chan_i.addr);

endmodule

// File: src/llc_burst_splitter.sv
module llc_burst_splitter (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // 1 for the aw splitter, 0 for ar
  input  logic           rw_i,
  // four-phase request from the master
  input  logic           chan_req_i,
  input  llc_pkg::chan_t chan_i,
  output logic           chan_ack_o,
  input  llc_pkg::rule_t cached_rule_i,
  input  llc_pkg::rule_t spm_rule_i,
  // four-phase descriptor output
  output logic           desc_req_o,
  output llc_pkg::desc_t desc_o,
  input  logic           desc_ack_i
);

  llc_pkg::split_state_t state_q;
  llc_pkg::split_state_t state_d;
  // remaining part of the burst still to be cut
  llc_pkg::chan_t        chan_q;
  llc_pkg::chan_t        chan_d;
  llc_pkg::chan_t        next_chan;

  // cutter always works on the stored channel so desc_o is stable
  llc_burst_cutter i_burst_cutter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .curr_chan_i   (chan_q),
    .rw_i          (rw_i),
    .cached_rule_i (cached_rule_i),
    .spm_rule_i    (spm_rule_i),
    .next_chan_o   (next_chan),
    .desc_o        (desc_o)
  );

  always_comb begin
    state_d = state_q;
    chan_d  = chan_q;

    unique case (state_q)
      llc_pkg::IDLE: begin
        // latch on the same edge that raises ack
        if (chan_req_i) begin
          chan_d  = chan_i;
          state_d = llc_pkg::CAPTURE_ACK;
        end
      end
      llc_pkg::CAPTURE_ACK: begin
        // first ack cycle, master may already have let go
        if (!chan_req_i) begin
          state_d = llc_pkg::DESC_REQ;
        end else begin
          state_d = llc_pkg::WAIT_REQ_LOW;
        end
      end
      llc_pkg::WAIT_REQ_LOW: begin
        // ack stays up until the master drops req
        if (!chan_req_i) begin
          state_d = llc_pkg::DESC_REQ;
        end
      end
      llc_pkg::DESC_REQ: begin
        // sink took the descriptor, drop req next edge
        if (desc_ack_i) begin
          state_d = llc_pkg::DESC_ACK_LOW;
        end
      end
      llc_pkg::DESC_ACK_LOW: begin
        // handshake closed, move on to the next line or finish
        if (!desc_ack_i) begin
          if (desc_o.last) begin
            state_d = llc_pkg::IDLE;
          end else begin
            chan_d  = next_chan;
            state_d = llc_pkg::DESC_REQ;
          end
        end
      end
      default: begin
        state_d = llc_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= llc_pkg::IDLE;
      chan_q  <= '0;
    end else begin
      state_q <= state_d;
      chan_q  <= chan_d;
    end
  end

  // ack covers both capture states
  assign chan_ack_o = (state_q == llc_pkg::CAPTURE_ACK) ||
                      (state_q == llc_pkg::WAIT_REQ_LOW);
  assign desc_req_o = (state_q == llc_pkg::DESC_REQ);

  // descriptor must not move under a pending request
  desc_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (desc_req_o && !desc_ack_i) |=> $stable(desc_o))
    else $error("burst splitter: descriptor changed while req pending");

endmodule

// File: src/llc_desc_arbiter.sv
module llc_desc_arbiter (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // write side, from the aw splitter
  input  logic           wr_req_i,
  input  llc_pkg::desc_t wr_desc_i,
  output logic           wr_ack_o,
  // read side, from the ar splitter
  input  logic           rd_req_i,
  input  llc_pkg::desc_t rd_desc_i,
  output logic           rd_ack_o,
  // merged stream
  output logic           desc_req_o,
  output llc_pkg::desc_t desc_o,
  input  logic           desc_ack_i
);

  // grant is locked while a handshake is in flight
  logic gnt_valid_q;
  // high when read holds or last held the grant
  logic gnt_rd_q;
  logic pick_rd;
  logic sel_rd;
  logic sel_req;

  // read wins if alone or if write had the last turn
  assign pick_rd = rd_req_i && (!wr_req_i || !gnt_rd_q);
  // locked grant or else a fresh pick this cycle
  assign sel_rd  = gnt_valid_q ? gnt_rd_q : pick_rd;
  assign sel_req = sel_rd ? rd_req_i : wr_req_i;

  assign desc_req_o = sel_req;
  assign desc_o     = sel_rd ? rd_desc_i : wr_desc_i;
  // ack only goes back to the winner
  assign wr_ack_o   = !sel_rd && desc_ack_i;
  assign rd_ack_o   = sel_rd && desc_ack_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_valid_q <= 1'b0;
      gnt_rd_q    <= 1'b0;
    end else if (!gnt_valid_q) begin
      // lock in the pick as soon as someone asks
      if (wr_req_i || rd_req_i) begin
        gnt_valid_q <= 1'b1;
        gnt_rd_q    <= pick_rd;
      end
    end else if (!sel_req && !desc_ack_i) begin
      // both sides back at zero so the output is free
      gnt_valid_q <= 1'b0;
    end
  end

  // no switching in the middle of a four-phase cycle
  grant_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (desc_req_o || desc_ack_i) |=> $stable(sel_rd))
    else $error("desc arbiter: grant changed during a handshake");

endmodule

// File: src/llc_desc_top.sv
module llc_desc_top (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // write address requests
  input  logic           aw_req_i,
  input  llc_pkg::chan_t aw_chan_i,
  output logic           aw_ack_o,
  // read address requests
  input  logic           ar_req_i,
  input  llc_pkg::chan_t ar_chan_i,
  output logic           ar_ack_o,
  // region map, shared by both channels
  input  llc_pkg::rule_t cached_rule_i,
  input  llc_pkg::rule_t spm_rule_i,
  // merged descriptor stream
  output logic           desc_req_o,
  output llc_pkg::desc_t desc_o,
  input  logic           desc_ack_i
);

  // splitter to arbiter handshakes
  logic           aw_desc_req;
  llc_pkg::desc_t aw_desc;
  logic           aw_desc_ack;
  logic           ar_desc_req;
  llc_pkg::desc_t ar_desc;
  logic           ar_desc_ack;

  // aw splitter, descriptors are writes
  llc_burst_splitter i_aw_splitter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .rw_i          (1'b1),
    .chan_req_i    (aw_req_i),
    .chan_i        (aw_chan_i),
    .chan_ack_o    (aw_ack_o),
    .cached_rule_i (cached_rule_i),
    .spm_rule_i    (spm_rule_i),
    .desc_req_o    (aw_desc_req),
    .desc_o        (aw_desc),
    .desc_ack_i    (aw_desc_ack)
  );

  llc_burst_splitter i_ar_splitter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .rw_i          (1'b0),
    .chan_req_i    (ar_req_i),
    .chan_i        (ar_chan_i),
    .chan_ack_o    (ar_ack_o),
    .cached_rule_i (cached_rule_i),
    .spm_rule_i    (spm_rule_i),
    .desc_req_o    (ar_desc_req),
    .desc_o        (ar_desc),
    .desc_ack_i    (ar_desc_ack)
  );

  llc_desc_arbiter i_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_req_i   (aw_desc_req),
    .wr_desc_i  (aw_desc),
    .wr_ack_o   (aw_desc_ack),
    .rd_req_i   (ar_desc_req),
    .rd_desc_i  (ar_desc),
    .rd_ack_o   (ar_desc_ack),
    .desc_req_o (desc_req_o),
    .desc_o     (desc_o),
    .desc_ack_i (desc_ack_i)
  );

endmodule

// File: verification/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset held for five cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    // release away from the active edge
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: verification/tb_llc_desc_top.sv
module tb_llc_desc_top;
  timeunit 1ns;
  timeprecision 1ps;

  logic           clk;
  logic           arst_n;
  logic           aw_req;
  logic           aw_ack;
  logic           ar_req;
  logic           ar_ack;
  logic           desc_req;
  logic           desc_ack;
  llc_pkg::chan_t aw_chan;
  llc_pkg::chan_t ar_chan;
  llc_pkg::rule_t cached_rule;
  llc_pkg::rule_t spm_rule;
  llc_pkg::desc_t desc;

  // expected descriptors per channel from the reference model
  llc_pkg::desc_t exp_wr_q[$];
  llc_pkg::desc_t exp_rd_q[$];
  int             errors;
  int             seed;
  // alternation check is armed in the concurrent test only
  logic           check_alt;
  logic           have_prev;
  logic           prev_rw;

  tb_clk_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  llc_desc_top i_llc_desc_top (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .aw_req_i      (aw_req),
    .aw_chan_i     (aw_chan),
    .aw_ack_o      (aw_ack),
    .ar_req_i      (ar_req),
    .ar_chan_i     (ar_chan),
    .ar_ack_o      (ar_ack),
    .cached_rule_i (cached_rule),
    .spm_rule_i    (spm_rule),
    .desc_req_o    (desc_req),
    .desc_o        (desc),
    .desc_ack_i    (desc_ack)
  );

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
      else abort_run($sformatf("mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  // reference model with one descriptor per line touched
  task automatic model_burst(input llc_pkg::chan_t c, input logic rw);
    longint unsigned addr;
    longint unsigned line_bytes;
    longint unsigned spm_end;
    int              beats_left;
    int              beats_line;
    llc_pkg::desc_t  d;
    addr       = c.addr;
    line_bytes = 1 << llc_pkg::LineOffset;
    spm_end    = spm_rule.start_addr + llc_pkg::SetAssoc * llc_pkg::WaySpmBytes;
    beats_left = c.len + 1;
    d          = '0;
    d.id       = c.id;
    d.size     = c.size;
    d.burst    = c.burst;
    d.rw       = rw;
    do begin
      d.addr    = llc_pkg::addr_t'(addr);
      // unmapped unless a region claims it
      d.spm     = 1'b1;
      d.way_ind = 4'b0001;
      d.resp    = llc_pkg::RespSlvErr;
      if ((addr >= cached_rule.start_addr) && (addr < cached_rule.end_addr)) begin
        d.spm     = 1'b0;
        d.way_ind = '0;
        d.resp    = llc_pkg::RespOkay;
      end else if ((addr >= spm_rule.start_addr) && (addr < spm_end)) begin
        // ways laid out back to back from the scratchpad base
        d.way_ind = llc_pkg::way_ind_t'(1 << ((addr - spm_rule.start_addr) /
                                              llc_pkg::WaySpmBytes));
        d.resp    = llc_pkg::RespOkay;
      end
      // beats up to the line end where a partial first beat rounds up
      beats_line = int'((line_bytes - addr % line_bytes + (1 << c.size) - 1) >> c.size);
      if ((c.burst != llc_pkg::BurstFixed) && (beats_line < beats_left)) begin
        d.len      = llc_pkg::len_t'(beats_line - 1);
        d.last     = 1'b0;
        addr       = (addr / line_bytes + 1) * line_bytes;
        beats_left = beats_left - beats_line;
      end else begin
        d.len  = llc_pkg::len_t'(beats_left - 1);
        d.last = 1'b1;
      end
      if (rw) exp_wr_q.push_back(d);
      else exp_rd_q.push_back(d);
    end while (!d.last);
  endtask

  // four-phase request on aw or ar
  task automatic send_req(input logic is_aw, input llc_pkg::chan_t c);
    @(negedge clk);
    if (is_aw) begin
      aw_chan = c;
      aw_req  = 1'b1;
    end else begin
      ar_chan = c;
      ar_req  = 1'b1;
    end
    do @(negedge clk); while (is_aw ? !aw_ack : !ar_ack);
    if (is_aw) aw_req = 1'b0;
    else ar_req = 1'b0;
    do @(negedge clk); while (is_aw ? aw_ack : ar_ack);
  endtask

  // one full descriptor handshake on the sink side
  task automatic accept_desc();
    llc_pkg::desc_t got;
    llc_pkg::desc_t exp;
    logic           both_busy;
    logic           from_wr;
    do @(negedge clk); while (!desc_req);
    got       = desc;
    both_busy = (exp_wr_q.size() != 0) && (exp_rd_q.size() != 0);
    assert ((exp_wr_q.size() != 0) || (exp_rd_q.size() != 0))
      else abort_run("descriptor arrived while none was expected");
    // with one channel outstanding the source is known without looking at rw
    if (both_busy) begin
      from_wr = got.rw;
    end else begin
      from_wr = (exp_wr_q.size() != 0);
    end
    exp = from_wr ? exp_wr_q[0] : exp_rd_q[0];
    check_field("desc.id", exp.id, got.id);
    check_field("desc.addr", exp.addr, got.addr);
    check_field("desc.len", exp.len, got.len);
    check_field("desc.size", exp.size, got.size);
    check_field("desc.burst", exp.burst, got.burst);
    check_field("desc.rw", exp.rw, got.rw);
    check_field("desc.spm", exp.spm, got.spm);
    check_field("desc.way_ind", exp.way_ind, got.way_ind);
    check_field("desc.resp", exp.resp, got.resp);
    check_field("desc.last", exp.last, got.last);
    // with both channels busy the winner must flip
    if (check_alt && have_prev && both_busy) begin
      assert (got.rw != prev_rw)
        else abort_run("arbiter granted the same channel twice while both were pending");
    end
    have_prev = 1'b1;
    prev_rw   = got.rw;
    desc_ack  = 1'b1;
    do @(negedge clk); while (desc_req);
    desc_ack = 1'b0;
    if (from_wr) void'(exp_wr_q.pop_front());
    else void'(exp_rd_q.pop_front());
  endtask

  task automatic wait_drain();
    while ((exp_wr_q.size() != 0) || (exp_rd_q.size() != 0)) @(negedge clk);
    // lets the splitter get back to idle
    repeat (3) @(negedge clk);
  endtask

  task automatic run_single(input logic is_aw, input llc_pkg::chan_t c);
    model_burst(c, is_aw);
    send_req(is_aw, c);
    wait_drain();
  endtask

  // region pick is cached for 0 and 1, scratchpad for 2 and unmapped for 3
  function automatic llc_pkg::chan_t draw_chan();
    logic [31:0]    r;
    llc_pkg::addr_t base;
    r = $random(seed);
    unique case (r[17:16])
      2'd2:    base = 32'h8000_0000;
      2'd3:    base = 32'h9000_0000;
      default: base = 32'h0000_0000;
    endcase
    return '{r[31:28], base + r[12:0], 8'(r[27:24]), 3'(r[21:20]), llc_pkg::BurstIncr};
  endfunction

  task automatic single_line_read();
    run_single(1'b0, '{4'h3, 32'h0000_0100, 8'd3, 3'd3, llc_pkg::BurstIncr});
  endtask

  // 16 beats of 8 bytes from line offset 8
  task automatic write_split();
    run_single(1'b1, '{4'h5, 32'h0000_1008, 8'd15, 3'd3, llc_pkg::BurstIncr});
  endtask

  task automatic fixed_burst();
    run_single(1'b0, '{4'h6, 32'h0000_2010, 8'd7, 3'd3, llc_pkg::BurstFixed});
  endtask

  task automatic decode_regions();
    // way 2 scratchpad and then an unmapped address
    run_single(1'b0, '{4'h7, 32'h8000_1040, 8'd0, 3'd2, llc_pkg::BurstIncr});
    run_single(1'b1, '{4'h8, 32'h4000_0000, 8'd1, 3'd2, llc_pkg::BurstIncr});
  endtask

  task automatic concurrent_channels();
    llc_pkg::chan_t aw_c;
    llc_pkg::chan_t ar_c;
    aw_c = '{4'h9, 32'h0000_3000, 8'd15, 3'd3, llc_pkg::BurstIncr};
    ar_c = '{4'ha, 32'h8000_0800, 8'd15, 3'd3, llc_pkg::BurstIncr};
    model_burst(aw_c, 1'b1);
    model_burst(ar_c, 1'b0);
    check_alt = 1'b1;
    have_prev = 1'b0;
    fork
      send_req(1'b1, aw_c);
      send_req(1'b0, ar_c);
    join
    wait_drain();
    check_alt = 1'b0;
  endtask

  task automatic random_bursts();
    llc_pkg::chan_t aw_list[20];
    llc_pkg::chan_t ar_list[20];
    for (int i = 0; i < 20; i++) begin
      aw_list[i] = draw_chan();
      ar_list[i] = draw_chan();
      model_burst(aw_list[i], 1'b1);
      model_burst(ar_list[i], 1'b0);
    end
    fork
      for (int i = 0; i < 20; i++) send_req(1'b1, aw_list[i]);
      for (int i = 0; i < 20; i++) send_req(1'b0, ar_list[i]);
    join
    wait_drain();
  endtask

  initial begin
    seed      = 82;
    errors    = 0;
    check_alt = 1'b0;
    have_prev = 1'b0;
    prev_rw   = 1'b0;
    aw_req    = 1'b0;
    aw_chan   = '0;
    ar_req    = 1'b0;
    ar_chan   = '0;
    desc_ack  = 1'b0;
    cached_rule.start_addr = 32'h0000_0000;
    cached_rule.end_addr   = 32'h1000_0000;
    // four ways of 2 KiB each
    spm_rule.start_addr    = 32'h8000_0000;
    spm_rule.end_addr      = 32'h8000_2000;
    wait (arst_n === 1'b1);
    single_line_read();
    write_split();
    fixed_burst();
    decode_regions();
    concurrent_channels();
    random_bursts();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // descriptor sink runs for the whole simulation
  initial begin
    wait (arst_n === 1'b1);
    forever accept_desc();
  end

  // six tests at 2000 ns each
  initial begin
    #(6 * 2000);
    $display("timeout: the tests did not finish in time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: all.f
src/llc_pkg.sv
src/llc_addr_decode.sv
src/llc_burst_cutter.sv
src/llc_burst_splitter.sv
src/llc_desc_arbiter.sv
src/llc_desc_top.sv
verification/tb_clk_gen.sv
verification/tb_llc_desc_top.sv
